// File: src.f
+incdir+.
dcache_pkg.sv
way_ram.sv
tag_lookup.sv
data_lookup.sv
axi_port.sv
cache_ctrl.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_dcache
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam word_t FILL_K = 32'h9e37_79b1;

    typedef struct packed {
        logic                    wr;
        addr_t                   addr;
        logic [`DC_WORD_W/8-1:0] wstrb;
        word_t                   wdata;
        word_t                   exp_rdata;
        logic                    chk_axi;
        logic                    exp_ar;
        logic                    exp_aw;
        addr_t                   wb_base;
        line_t                   exp_line;
    } vec_t;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    rd_req_t  rd_req;
    rd_rsp_t  rd_rsp;
    wr_req_t  wr_req;
    wr_rsp_t  wr_rsp;
    int       ar_count;
    int       aw_count;

    vec_t  table_q [$];
    word_t shadow [addr_t];
    int    cycles   = 0;
    int    limit    = 0;
    int    accepted = 0;
    int    ok_count = 0;

    dcache_top UUT (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp)
    );

    tb_axi_mem u_mem (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp),
        .wr_req   (wr_req),
        .wr_rsp   (wr_rsp),
        .ar_count (ar_count),
        .aw_count (aw_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the DUT gave no response within %0d cycles", limit);
            abort_run();
        end
    end

    // one count per data_ok cycle
    always @(negedge clk) begin
        if (rst && cpu_rsp.data_ok) begin
            ok_count++;
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic word_equal(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic addr_equal(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic flag_equal(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic count_equal(string name, int got, int exp);
        if (got != exp) begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    function automatic word_t shadow_word(addr_t a);
        if (shadow.exists(a >> 2)) begin
            return shadow[a >> 2];
        end
        return (a >> 2) * FILL_K;
    endfunction

    // expected values are taken before the entry's own store lands
    function automatic void add_entry(logic wr, addr_t addr, logic [`DC_WORD_W/8-1:0] wstrb,
                                      word_t wdata, logic chk_axi, logic exp_ar,
                                      logic exp_aw, addr_t wb_base);
        vec_t  v;
        word_t cur;
        cur         = shadow_word(addr);
        v.wr        = wr;
        v.addr      = addr;
        v.wstrb     = wstrb;
        v.wdata     = wdata;
        v.exp_rdata = cur;
        v.chk_axi   = chk_axi;
        v.exp_ar    = exp_ar;
        v.exp_aw    = exp_aw;
        v.wb_base   = wb_base;
        for (int i = 0; i < `DC_WORDS; i++) begin
            v.exp_line[i] = shadow_word(wb_base + addr_t'(4 * i));
        end
        if (wr) begin
            for (int b = 0; b < `DC_WORD_W/8; b++) begin
                if (wstrb[b]) begin
                    cur[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            shadow[addr >> 2] = cur;
        end
        table_q.push_back(v);
    endfunction

    function automatic void build_table();
        logic [`DC_WORD_W/8-1:0] strb;
        addr_t                   a;
        // lines a, b and c share set 2
        add_entry(1'b0, 32'h0000_104c, 4'h0, '0, 1'b1, 1'b1, 1'b0, '0);
        add_entry(1'b0, 32'h0000_1054, 4'h0, '0, 1'b1, 1'b0, 1'b0, '0);
        add_entry(1'b1, 32'h0000_1048, 4'b0101, 32'haabb_ccdd, 1'b1, 1'b0, 1'b0, '0);
        add_entry(1'b0, 32'h0000_1048, 4'h0, '0, 1'b1, 1'b0, 1'b0, '0);
        add_entry(1'b0, 32'h0000_2044, 4'h0, '0, 1'b1, 1'b1, 1'b0, '0);
        // dirty line a is the victim
        add_entry(1'b0, 32'h0000_3050, 4'h0, '0, 1'b1, 1'b1, 1'b1, 32'h0000_1040);
        // clean line b goes without a write burst
        add_entry(1'b0, 32'h0000_1048, 4'h0, '0, 1'b1, 1'b1, 1'b0, '0);
        add_entry(1'b0, 32'h0000_3050, 4'h0, '0, 1'b1, 1'b0, 1'b0, '0);
        // store miss allocates
        add_entry(1'b1, 32'h0000_4060, 4'hf, 32'h1234_5678, 1'b1, 1'b1, 1'b0, '0);
        add_entry(1'b0, 32'h0000_4060, 4'h0, '0, 1'b1, 1'b0, 1'b0, '0);
        // mixed traffic, three tags over sets 20 and 21
        for (int i = 0; i < 24; i++) begin
            strb = 4'b0011 << (i % 3);
            a    = {tag_t'(5 + i % 3), index_t'(20 + i % 2), woff_t'(3 * i), 2'b00};
            add_entry(i % 3 == 1, a, strb, word_t'(32'h1000_0000 + i * 32'h0101_0101),
                      1'b0, 1'b0, 1'b0, '0);
        end
    endfunction

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////

    task automatic watch_sweep();
        for (int i = 0; i < `DC_SETS; i++) begin
            flag_equal("addr_ok during sweep", cpu_rsp.addr_ok, 1'b0);
            flag_equal("data_ok during sweep", cpu_rsp.data_ok, 1'b0);
            flag_equal("arvalid during sweep", rd_req.arvalid, 1'b0);
            flag_equal("rready during sweep", rd_req.rready, 1'b0);
            flag_equal("awvalid during sweep", wr_req.awvalid, 1'b0);
            flag_equal("wvalid during sweep", wr_req.wvalid, 1'b0);
            flag_equal("wlast during sweep", wr_req.wlast, 1'b0);
            flag_equal("bready during sweep", wr_req.bready, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic apply_entry(vec_t v, int idx);
        int ar0;
        int aw0;
        int nb0;
        int lat;
        ar0 = ar_count;
        aw0 = aw_count;
        nb0 = u_mem.beat_addr.size();
        cpu_req.req   = 1'b1;
        cpu_req.wr    = v.wr;
        cpu_req.addr  = v.addr;
        cpu_req.wstrb = v.wstrb;
        cpu_req.wdata = v.wdata;
        while (!cpu_rsp.addr_ok) begin
            @(negedge clk);
        end
        accepted++;
        @(negedge clk);
        cpu_req = '0;
        lat     = 1;
        while (!cpu_rsp.data_ok) begin
            @(negedge clk);
            lat++;
        end
        if (!v.wr) begin
            word_equal($sformatf("entry %0d rdata", idx), cpu_rsp.rdata, v.exp_rdata);
        end
        if (v.chk_axi) begin
            count_equal($sformatf("entry %0d AR count", idx), ar_count - ar0, int'(v.exp_ar));
            count_equal($sformatf("entry %0d AW count", idx), aw_count - aw0, int'(v.exp_aw));
            if (!v.exp_ar && !v.exp_aw) begin
                count_equal($sformatf("entry %0d hit latency", idx), lat, 2);
            end
        end
        // read burst starts at the missed word
        if (v.chk_axi && v.exp_ar) begin
            addr_equal($sformatf("entry %0d araddr", idx),
                       u_mem.ar_addr[u_mem.ar_addr.size() - 1], v.addr & ~addr_t'(3));
        end
        if (v.chk_axi && v.exp_aw) begin
            count_equal("write beats", u_mem.beat_addr.size() - nb0, `DC_WORDS);
            for (int i = 0; i < `DC_WORDS; i++) begin
                addr_equal($sformatf("beat %0d awaddr", i), u_mem.beat_addr[nb0 + i],
                           v.wb_base + addr_t'(4 * i));
                word_equal($sformatf("beat %0d wdata", i), u_mem.beat_data[nb0 + i],
                           v.exp_line[i]);
                flag_equal($sformatf("beat %0d wlast", i), u_mem.beat_last[nb0 + i],
                           i == `DC_WORDS - 1);
            end
        end
    endtask

    initial begin
        rst     = 1'b0;
        cpu_req = '0;
        build_table();
        limit = table_q.size() * 200 + 300;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        watch_sweep();
        foreach (table_q[i]) begin
            apply_entry(table_q[i], i);
        end
        // let any stray data_ok show up in the count
        repeat (4) @(negedge clk);
        @(posedge clk);
        count_equal("data_ok pulses", ok_count, accepted);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module tb_axi_mem import dcache_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire rd_req_t rd_req,
    output rd_rsp_t      rd_rsp,
    input  wire wr_req_t wr_req,
    output wr_rsp_t      wr_rsp,
    output int           ar_count,
    output int           aw_count
);

    // odd multiplier, so every word address gives its own value
    localparam word_t FILL_K = 32'h9e37_79b1;

    // keyed by word address, holds only words written by bursts
    word_t mem [addr_t];

    // every read address accepted, in order
    addr_t ar_addr [$];

    // every write beat seen, in order
    addr_t beat_addr [$];
    word_t beat_data [$];
    logic  beat_last [$];

    function automatic int rand_delay();
        return $urandom_range(3, 0);
    endfunction

    function automatic word_t read_word(addr_t a);
        addr_t wa;
        wa = a >> 2;
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa * FILL_K;
    endfunction

    ////////////////////////////////////////
    // read bursts, wrapping from the missed word
    ////////////////////////////////////////

    task automatic serve_reads();
        addr_t base;
        woff_t start;
        forever begin
            @(negedge clk);
            if (rst && rd_req.arvalid) begin
                repeat (rand_delay()) @(negedge clk);
                rd_rsp.arready = 1'b1;
                ar_count++;
                ar_addr.push_back(rd_req.araddr);
                base  = {rd_req.araddr[`DC_ADDR_W-1:`DC_WOFF_W+2], {(`DC_WOFF_W+2){1'b0}}};
                start = rd_req.araddr[2 +: `DC_WOFF_W];
                @(negedge clk);
                rd_rsp.arready = 1'b0;
                for (int b = 0; b < `DC_WORDS; b++) begin
                    repeat (rand_delay()) @(negedge clk);
                    rd_rsp.rvalid = 1'b1;
                    rd_rsp.rdata  = read_word(base + addr_t'({start + woff_t'(b), 2'b00}));
                    rd_rsp.rlast  = (b == `DC_WORDS - 1);
                    // beat completes only with rready
                    while (!rd_req.rready) begin
                        @(negedge clk);
                    end
                    @(negedge clk);
                    rd_rsp.rvalid = 1'b0;
                    rd_rsp.rlast  = 1'b0;
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // write bursts, incrementing from the line base
    ////////////////////////////////////////

    task automatic serve_writes();
        addr_t base;
        forever begin
            @(negedge clk);
            if (rst && wr_req.awvalid) begin
                repeat (rand_delay()) @(negedge clk);
                wr_rsp.awready = 1'b1;
                aw_count++;
                base = wr_req.awaddr;
                @(negedge clk);
                wr_rsp.awready = 1'b0;
                for (int b = 0; b < `DC_WORDS; b++) begin
                    repeat (rand_delay()) @(negedge clk);
                    wr_rsp.wready = 1'b1;
                    // beat completes only with wvalid
                    while (!wr_req.wvalid) begin
                        @(negedge clk);
                    end
                    beat_addr.push_back(base + addr_t'(4 * b));
                    beat_data.push_back(wr_req.wdata);
                    beat_last.push_back(wr_req.wlast);
                    mem[(base >> 2) + addr_t'(b)] = wr_req.wdata;
                    @(negedge clk);
                    wr_rsp.wready = 1'b0;
                end
                repeat (rand_delay()) @(negedge clk);
                wr_rsp.bvalid = 1'b1;
                while (!wr_req.bready) begin
                    @(negedge clk);
                end
                @(negedge clk);
                wr_rsp.bvalid = 1'b0;
            end
        end
    endtask

    initial begin
        rd_rsp   = '0;
        wr_rsp   = '0;
        ar_count = 0;
        aw_count = 0;
        void'($urandom(64));
        fork
            serve_reads();
            serve_writes();
        join
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire cpu_req_t cpu_req,
    output cpu_rsp_t      cpu_rsp,
    output rd_req_t       rd_req,
    input  wire rd_rsp_t  rd_rsp,
    output wr_req_t       wr_req,
    input  wire wr_rsp_t  wr_rsp
);

    // lookup control from the controller
    index_t                  rindex;
    index_t                  windex;
    tag_t                    tag;
    logic [1:0]              tag_we;
    tag_entry_t              wentry;
    logic                    set_dirty;
    logic                    clr_dirty;
    logic                    fill;
    woff_t                   woff;
    logic                    way_sel;
    logic [1:0]              line_we;
    line_t                   wline;
    logic                    store_we;
    logic [`DC_WORD_W/8-1:0] wstrb;
    word_t                   wdata;

    // lookup results
    lookup_t                 result;
    word_t                   rword;
    line_t                   victim_line;

    // memory traffic
    logic                    start_refill;
    addr_t                   refill_addr;
    logic                    start_wb;
    addr_t                   wb_addr;
    line_t                   wb_line;
    line_t                   refill_line;
    logic                    refill_done;
    logic                    wb_done;

    tag_lookup  u_tag_lookup  (.*);
    data_lookup u_data_lookup (.*);
    axi_port    u_axi_port    (.*);
    cache_ctrl  u_cache_ctrl  (.*);

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module cache_ctrl import dcache_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire cpu_req_t      cpu_req,
    output cpu_rsp_t           cpu_rsp,
    input  wire lookup_t       result,
    input  wire word_t         rword,
    input  wire line_t         victim_line,
    input  wire line_t         refill_line,
    input  wire logic          refill_done,
    input  wire logic          wb_done,
    output index_t             rindex,
    output index_t             windex,
    output tag_t               tag,
    output logic [1:0]         tag_we,
    output tag_entry_t         wentry,
    output logic               set_dirty,
    output logic               clr_dirty,
    output logic               fill,
    output woff_t              woff,
    output logic               way_sel,
    output logic [1:0]         line_we,
    output line_t              wline,
    output logic               store_we,
    output logic [`DC_WORD_W/8-1:0] wstrb,
    output word_t              wdata,
    output logic               start_refill,
    output addr_t              refill_addr,
    output logic               start_wb,
    output addr_t              wb_addr,
    output line_t              wb_line
);

    ctrl_state_t state;
    cpu_req_t    req_q;
    index_t      sweep_cnt;
    index_t      req_index;
    logic        data_ok_q;
    word_t       rdata_q;
    logic        accept;

    // addr_ok drops for the cycle of data_ok
    assign cpu_rsp.addr_ok = (state == IDLE) && !data_ok_q;
    assign cpu_rsp.data_ok = data_ok_q;
    assign cpu_rsp.rdata   = rdata_q;
    assign accept          = cpu_req.req && cpu_rsp.addr_ok;

    ////////////////////////////////////////
    // array addressing
    ////////////////////////////////////////

    assign req_index = req_q.addr[`DC_WOFF_W+2 +: `DC_INDEX_W];
    // idle reads straight from the cpu so the tags are ready next cycle
    assign rindex    = (state == SWEEP) ? sweep_cnt :
                       (state == IDLE)  ? cpu_req.addr[`DC_WOFF_W+2 +: `DC_INDEX_W] :
                       req_index;
    assign windex    = (state == SWEEP) ? sweep_cnt : req_index;

    assign tag         = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign woff        = req_q.addr[2 +: `DC_WOFF_W];
    assign wstrb       = req_q.wstrb;
    assign wdata       = req_q.wdata;
    assign way_sel     = result.hit ? result.hit_way : result.victim_way;
    assign wline       = refill_line;
    assign wb_line     = victim_line;
    assign refill_addr = {req_q.addr[`DC_ADDR_W-1:2], 2'b00};
    assign wb_addr     = {result.victim_tag, req_index, {(`DC_WOFF_W+2){1'b0}}};

    always_comb begin
        tag_we       = 2'b00;
        line_we      = 2'b00;
        wentry.valid = 1'b0;
        wentry.tag   = tag;
        set_dirty    = 1'b0;
        clr_dirty    = 1'b0;
        fill         = 1'b0;
        store_we     = 1'b0;
        start_wb     = 1'b0;
        start_refill = 1'b0;
        case (state)
            SWEEP: begin
                tag_we    = 2'b11;
                clr_dirty = 1'b1;
            end
            LOOKUP: begin
                if (result.hit) begin
                    store_we  = req_q.wr;
                    set_dirty = req_q.wr;
                end else if (result.victim_dirty) begin
                    start_wb = 1'b1;
                end else begin
                    start_refill = 1'b1;
                end
            end
            WRITEBACK: start_refill = wb_done;
            FILL: begin
                tag_we       = {result.victim_way, ~result.victim_way};
                line_we      = tag_we;
                wentry.valid = 1'b1;
                clr_dirty    = 1'b1;
                fill         = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= (state == LOOKUP) && result.hit;
            case (state)
                SWEEP: begin
                    sweep_cnt <= sweep_cnt + index_t'(1);
                    if (&sweep_cnt) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (result.hit) begin
                        state <= IDLE;
                    end else if (result.victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    if (wb_done) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (refill_done) begin
                        state <= FILL;
                    end
                end
                // the new line needs one more read before it can hit
                FILL:    state <= REREAD;
                REREAD:  state <= LOOKUP;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if ((state == LOOKUP) && result.hit) begin
            rdata_q <= rword;
        end
    end

endmodule

`default_nettype wire

// File: axi_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module axi_port import dcache_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    start_refill,
    input  wire addr_t   refill_addr,
    input  wire logic    start_wb,
    input  wire addr_t   wb_addr,
    input  wire line_t   wb_line,
    output rd_req_t      rd_req,
    input  wire rd_rsp_t rd_rsp,
    output wr_req_t      wr_req,
    input  wire wr_rsp_t wr_rsp,
    output line_t        refill_line,
    output logic         refill_done,
    output logic         wb_done
);

    ////////////////////////////////////////
    // read burst collector
    ////////////////////////////////////////

    addr_t araddr_q;
    logic  ar_pend;
    logic  r_act;
    woff_t rcnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ar_pend     <= 1'b0;
            r_act       <= 1'b0;
            rcnt        <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            if (start_refill) begin
                ar_pend <= 1'b1;
                // first beat carries the missed word
                rcnt    <= refill_addr[2 +: `DC_WOFF_W];
            end else if (ar_pend && rd_rsp.arready) begin
                ar_pend <= 1'b0;
                r_act   <= 1'b1;
            end else if (r_act && rd_rsp.rvalid) begin
                rcnt <= rcnt + woff_t'(1);
                if (rd_rsp.rlast) begin
                    r_act       <= 1'b0;
                    refill_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_refill) begin
            araddr_q <= {refill_addr[`DC_ADDR_W-1:2], 2'b00};
        end
        if (r_act && rd_rsp.rvalid) begin
            refill_line[rcnt] <= rd_rsp.rdata;
        end
    end

    always_comb begin
        rd_req.araddr  = araddr_q;
        rd_req.arvalid = ar_pend;
        rd_req.rready  = r_act;
    end

    ////////////////////////////////////////
    // write burst sender
    ////////////////////////////////////////

    addr_t awaddr_q;
    line_t wbuf;
    logic  aw_pend;
    logic  w_act;
    logic  b_wait;
    woff_t wcnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            aw_pend <= 1'b0;
            w_act   <= 1'b0;
            b_wait  <= 1'b0;
            wcnt    <= '0;
            wb_done <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            if (start_wb) begin
                aw_pend <= 1'b1;
                wcnt    <= '0;
            end else if (aw_pend && wr_rsp.awready) begin
                aw_pend <= 1'b0;
                w_act   <= 1'b1;
            end else if (w_act && wr_rsp.wready) begin
                wcnt <= wcnt + woff_t'(1);
                if (&wcnt) begin
                    w_act  <= 1'b0;
                    b_wait <= 1'b1;
                end
            end else if (b_wait && wr_rsp.bvalid) begin
                b_wait  <= 1'b0;
                wb_done <= 1'b1;
            end
        end
    end

    // victim is copied so the arrays are free during the burst
    always_ff @(posedge clk) begin
        if (start_wb) begin
            awaddr_q <= {wb_addr[`DC_ADDR_W-1:`DC_WOFF_W+2], {(`DC_WOFF_W+2){1'b0}}};
            wbuf     <= wb_line;
        end
    end

    always_comb begin
        wr_req.awaddr  = awaddr_q;
        wr_req.awvalid = aw_pend;
        wr_req.wdata   = wbuf[wcnt];
        wr_req.wvalid  = w_act;
        wr_req.wlast   = w_act && (&wcnt);
        wr_req.bready  = b_wait;
    end

endmodule

`default_nettype wire

// File: data_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module data_lookup import dcache_pkg::*; (
    input  wire logic                    clk,
    input  wire index_t                  rindex,
    input  wire woff_t                   woff,
    input  wire logic                    way_sel,
    input  wire logic [1:0]              line_we,
    input  wire index_t                  windex,
    input  wire line_t                   wline,
    input  wire logic                    store_we,
    input  wire logic [`DC_WORD_W/8-1:0] wstrb,
    input  wire word_t                   wdata,
    output word_t                        rword,
    output line_t                        victim_line
);

    line_t [1:0] line_q;
    line_t       sel_line;
    line_t       merged;
    line_t       ram_wdata;
    logic [1:0]  ram_we;

    // a store rewrites the whole line of the selected way
    assign ram_we    = line_we | ({2{store_we}} & {way_sel, ~way_sel});
    assign ram_wdata = store_we ? merged : wline;

    for (genvar w = 0; w < 2; w++) begin : g_way
        way_ram #(.entry_t(line_t)) u_line_ram (
            .clk    (clk),
            .rindex (rindex),
            .windex (windex),
            .we     (ram_we[w]),
            .wdata  (ram_wdata),
            .rdata  (line_q[w])
        );
    end

    assign sel_line    = line_q[way_sel];
    assign rword       = sel_line[woff];
    assign victim_line = sel_line;

    // byte merge into the addressed word
    always_comb begin
        merged = sel_line;
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (wstrb[b]) begin
                merged[woff][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: tag_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module tag_lookup import dcache_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire index_t     rindex,
    input  wire tag_t       tag,
    input  wire logic [1:0] tag_we,
    input  wire index_t     windex,
    input  wire tag_entry_t wentry,
    input  wire logic       set_dirty,
    input  wire logic       clr_dirty,
    input  wire logic       fill,
    output lookup_t         result
);

    tag_entry_t [1:0]         entry;
    logic [1:0]               hit_vec;
    logic [`DC_SETS-1:0][1:0] dirty;
    logic [`DC_SETS-1:0]      lru;
    index_t                   rindex_q;
    logic                     victim;

    for (genvar w = 0; w < 2; w++) begin : g_way
        way_ram #(.entry_t(tag_entry_t)) u_tag_ram (
            .clk    (clk),
            .rindex (rindex),
            .windex (windex),
            .we     (tag_we[w]),
            .wdata  (wentry),
            .rdata  (entry[w])
        );

        assign hit_vec[w] = entry[w].valid && (entry[w].tag == tag);
    end

    // keeps dirty and lru aligned with the ram output
    always_ff @(posedge clk) begin
        rindex_q <= rindex;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dirty <= '0;
            lru   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (clr_dirty && tag_we[w]) begin
                    dirty[windex][w] <= 1'b0;
                end
            end
            if (set_dirty) begin
                dirty[windex][result.hit_way] <= 1'b1;
            end
            // point at the way not just filled
            if (fill) begin
                lru[windex] <= tag_we[0];
            end
        end
    end

    always_comb begin
        victim              = lru[rindex_q];
        result.hit          = |hit_vec;
        result.hit_way      = hit_vec[1];
        result.victim_way   = victim;
        result.victim_dirty = dirty[rindex_q][victim];
        result.victim_tag   = entry[victim].tag;
    end

endmodule

`default_nettype wire

// File: way_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module way_ram import dcache_pkg::*; #(
    parameter type entry_t = logic
) (
    input  wire logic   clk,
    input  wire index_t rindex,
    input  wire index_t windex,
    input  wire logic   we,
    input  wire entry_t wdata,
    output entry_t      rdata
);

    entry_t mem [`DC_SETS];

    // same-address read returns the old entry
    always_ff @(posedge clk) begin
        if (we) begin
            mem[windex] <= wdata;
        end
        rdata <= mem[rindex];
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]  addr_t;
    typedef logic [`DC_WORD_W-1:0]  word_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_WOFF_W-1:0]  woff_t;

    // word 0 in the low bits
    typedef word_t [`DC_WORDS-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic                    req;
        logic                    wr;
        addr_t                   addr;
        logic [`DC_WORD_W/8-1:0] wstrb;
        word_t                   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

    // reduced axi read channels
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } rd_req_t;

    typedef struct packed {
        logic  arready;
        word_t rdata;
        logic  rvalid;
        logic  rlast;
    } rd_rsp_t;

    // reduced axi write channels
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        word_t wdata;
        logic  wvalid;
        logic  wlast;
        logic  bready;
    } wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } wr_rsp_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL,
        REREAD
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// bus widths
`define DC_ADDR_W  32
`define DC_WORD_W  32

// cache geometry
`define DC_SETS    128
`define DC_INDEX_W 7
`define DC_WORDS   8
`define DC_WOFF_W  3

// tag is what is left above index and line offset
`define DC_TAG_W   20

`endif
